// File: compile.f
logic/link_pkg.sv
logic/link_reset_sync.sv
logic/link_tx_fifo.sv
logic/link_tx_ctrl.sv
logic/link_tx_io.sv
logic/link_tx_top.sv
test/link_tx_tb.sv

// File: Bender.yml
package:
  name: link_tx

sources:
  - logic/link_pkg.sv
  - logic/link_reset_sync.sv
  - logic/link_tx_fifo.sv
  - logic/link_tx_ctrl.sv
  - logic/link_tx_io.sv
  - logic/link_tx_top.sv
  - target: test
    files:
      - test/link_tx_tb.sv

// File: test/link_tx_tb.sv
/*
 link tx testbench
 wishbone register and data tests, ddr pin monitor against a scoreboard
*/
`default_nettype none

module link_tx_tb;
   import link_pkg::*;

   localparam int period    = 10;
   localparam int depth     = 8;    // fifo depth of the dut
   localparam int bus_limit = 40;   // cycles allowed for an ack
   // test lengths in cycles for reset, ctrl, stream, wait, queue and full
   localparam int run_len   = 60 + 50 + 150 + 300 + 150 + 200;

   logic                clk = 1'b0;
   logic                io_nreset;
   wb_req_t             wb_req;
   wb_rsp_t             wb_rsp;
   logic                tx_access;
   logic [link_iow-1:0] tx_packet;
   logic                tx_wait = 1'b0;

   link_word_t          exp_q[$];             // scoreboard in push order
   logic [link_iow-1:0] lo_seen;              // mid high phase
   logic [link_iow-1:0] hi_seen;              // mid low phase
   link_word_t          rd;
   link_word_t          last;
   logic                acked;
   logic [15:0]         data_lfsr = 16'd11119;
   logic [15:0]         wait_lfsr = 16'd11119;
   logic                wait_random = 1'b0;   // random far end pushback
   logic                quiet = 1'b0;         // pins must stay idle
   int                  errors = 0;
   int                  err_mark = 0;
   int                  n_tests = 0;
   int                  n_failed = 0;
   int                  sent_total = 0;       // words the sent reg should show
   string               test_name = "";

   link_tx_top #(.fifo_depth(depth)) u_link_tx_top (
      .clk       (clk),
      .io_nreset (io_nreset),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_wait   (tx_wait)
   );

   always #(period/2) clk = ~clk;

   //########################################
   //# helpers
   //########################################

   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic link_word_t rand_word();
      link_word_t w;
      w = '0;
      for (int i = 0; i < link_word_w; i++) begin
         data_lfsr = lfsr_next(data_lfsr);           // one step per bit
         w = {w[link_word_w-2:0], data_lfsr[0]};
      end
      return w;
   endfunction

   // count in 15:0, empty at 16, full at 17
   function automatic link_word_t status_word(int cnt, logic emp, logic ful);
      return {14'd0, ful, emp, 16'(cnt)};
   endfunction

   function automatic void expect_eq(string what, link_word_t exp, link_word_t act);
      assert (act === exp) else begin
         $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
         errors++;
      end
   endfunction

   // classic cycle held until ack
   task automatic bus_access(input logic we, input logic [1:0] adr,
                             input link_word_t wdat, output link_word_t rdat);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_req <= {1'b1, 1'b1, we, adr, wdat};   // cyc stb we adr dat
      do begin
         @(posedge clk);
         waited++;
      end while (!wb_rsp.ack && waited < bus_limit);
      rdat = wb_rsp.dat;
      wb_req <= '0;                            // stb drops after ack
      if (!wb_rsp.ack) begin
         $display("%s: no wishbone ack within %0d cycles", test_name, bus_limit);
         errors++;
      end else begin
         expect_eq("ack latency", 3, waited);   // sample, decide, ack seen
         if (we && adr == reg_txdata) begin
            exp_q.push_back(wdat);
            sent_total++;
         end
      end
   endtask

   // drain the scoreboard and compare the sent register
   task automatic check_drained();
      link_word_t cnt;
      int n;
      n = 0;
      while (exp_q.size() > 0 && n < 400) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() > 0) begin
         $display("%s: %0d words never reached the pins", test_name, exp_q.size());
         errors++;
         exp_q.delete();
      end
      bus_access(1'b0, reg_sent, '0, cnt);
      expect_eq("sent", sent_total, cnt);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_mark  = errors;
      n_tests++;
   endtask

   task automatic end_test();
      if (errors != err_mark)
         n_failed++;
      $display("%-8s %s", test_name, (errors == err_mark) ? "ok" : "failed");
   endtask

   //########################################
   //# far end model and checks
   //########################################

   always @(posedge clk) begin
      if (wait_random) begin
         wait_lfsr = lfsr_next(wait_lfsr);
         tx_wait <= wait_lfsr[0];   // about half the edges
      end else begin
         tx_wait <= 1'b0;
      end
   end

   always @(posedge clk) begin
      #(period/5);
      lo_seen = tx_packet;
   end

   always @(negedge clk) begin
      #(period/5);
      hi_seen = tx_packet;
   end

   // word shown last cycle is taken on an edge with tx_wait low
   always @(posedge clk) begin
      if (tx_access === 1'b1 && tx_wait === 1'b0) begin
         assert (exp_q.size() > 0) else begin
            $display("%s: word %h on the pins with none expected", test_name,
                     {hi_seen, lo_seen});
            errors++;
         end
         if (exp_q.size() > 0)
            expect_eq("pin word", exp_q.pop_front(), {hi_seen, lo_seen});
      end
   end

   a_wait_hold: assert property (@(posedge clk) disable iff (!io_nreset)
      tx_wait && tx_access |=> tx_access && $stable({hi_seen, lo_seen}))
      else begin
         $display("%s: pins moved while tx_wait was high", test_name);
         errors++;
      end

   a_quiet_pins: assert property (@(posedge clk) disable iff (!io_nreset)
      quiet |-> !tx_access)
      else begin
         $display("%s: pin activity while transmit was disabled", test_name);
         errors++;
      end

   a_ack_in_cycle: assert property (@(posedge clk) disable iff (!io_nreset)
      wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
      else begin
         $display("%s: ack outside a bus cycle", test_name);
         errors++;
      end

   //########################################
   //# tests
   //########################################

   initial begin
      io_nreset = 1'b0;
      wb_req    = '0;
      repeat (4) @(posedge clk);
      io_nreset <= 1'b1;
      repeat (3) @(posedge clk);   // sync release plus margin

      start_test("reset");
      expect_eq("tx_access", 0, tx_access);
      expect_eq("ack", 0, wb_rsp.ack);
      bus_access(1'b0, reg_status, '0, rd);
      expect_eq("status", status_word(0, 1'b1, 1'b0), rd);
      bus_access(1'b0, reg_ctrl, '0, rd);
      expect_eq("ctrl", 0, rd);
      bus_access(1'b0, reg_sent, '0, rd);
      expect_eq("sent", 0, rd);
      end_test();

      start_test("ctrl");
      bus_access(1'b1, reg_ctrl, 32'd1, rd);
      bus_access(1'b0, reg_ctrl, '0, rd);
      expect_eq("enable set", 1, rd);
      bus_access(1'b1, reg_ctrl, 32'd0, rd);
      bus_access(1'b0, reg_ctrl, '0, rd);
      expect_eq("enable clear", 0, rd);
      end_test();

      start_test("stream");
      bus_access(1'b1, reg_ctrl, 32'd1, rd);
      repeat (10) bus_access(1'b1, reg_txdata, rand_word(), rd);
      check_drained();
      end_test();

      start_test("wait");
      @(negedge clk);
      wait_random = 1'b1;
      repeat (12) bus_access(1'b1, reg_txdata, rand_word(), rd);
      check_drained();
      @(negedge clk);
      wait_random = 1'b0;
      end_test();

      start_test("queue");
      bus_access(1'b1, reg_ctrl, 32'd0, rd);
      quiet = 1'b1;
      repeat (5) bus_access(1'b1, reg_txdata, rand_word(), rd);
      bus_access(1'b0, reg_status, '0, rd);
      expect_eq("status", status_word(5, 1'b0, 1'b0), rd);
      quiet = 1'b0;
      bus_access(1'b1, reg_ctrl, 32'd1, rd);
      check_drained();
      end_test();

      start_test("full");
      bus_access(1'b1, reg_ctrl, 32'd0, rd);
      repeat (depth) bus_access(1'b1, reg_txdata, rand_word(), rd);
      bus_access(1'b0, reg_status, '0, rd);
      expect_eq("status", status_word(depth, 1'b0, 1'b1), rd);
      last  = rand_word();
      acked = 1'b0;
      @(posedge clk);
      wb_req <= {1'b1, 1'b1, 1'b1, reg_txdata, last};
      repeat (12) begin
         @(posedge clk);
         if (wb_rsp.ack)
            acked = 1'b1;
      end
      wb_req <= '0;   // abandon the stalled cycle
      assert (!acked) else begin
         $display("%s: txdata write into a full fifo was acknowledged", test_name);
         errors++;
      end
      bus_access(1'b1, reg_ctrl, 32'd1, rd);
      bus_access(1'b1, reg_txdata, last, rd);   // retry lands behind the queue
      check_drained();
      end_test();

      $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   // watchdog
   initial begin
      repeat (4*run_len) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", 4*run_len);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/link_tx_top.sv
/*
 link transmit top
 reset sync, wishbone control, word fifo and ddr io block
*/
`default_nettype none

module link_tx_top #(
   parameter int fifo_depth = 8
) (
   input  logic                          clk,
   input  logic                          io_nreset,
   // host
   input  link_pkg::wb_req_t             wb_req,
   output link_pkg::wb_rsp_t             wb_rsp,
   // pins
   output logic                          tx_access,
   output logic [link_pkg::link_iow-1:0] tx_packet,
   input  logic                          tx_wait
);
   import link_pkg::*;

   logic        rst_n;
   logic        push, pop;
   link_word_t  push_data, pop_data;
   logic [15:0] count;
   logic        full, empty;
   logic        io_access, io_taken;
   link_word_t  io_packet;

   link_reset_sync u_reset_sync (
      .clk       (clk),
      .io_nreset (io_nreset),
      .rst_n     (rst_n)
   );

   link_tx_ctrl #(.fifo_depth(fifo_depth)) u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .count     (count),
      .full      (full),
      .empty     (empty),
      .io_access (io_access),
      .io_packet (io_packet),
      .io_taken  (io_taken)
   );

   link_tx_fifo #(.fifo_depth(fifo_depth)) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .count     (count),
      .full      (full),
      .empty     (empty)
   );

   link_tx_io u_io (
      .clk       (clk),
      .rst_n     (rst_n),
      .io_access (io_access),
      .io_packet (io_packet),
      .io_taken  (io_taken),
      .tx_access (tx_access),
      .tx_packet (tx_packet),
      .tx_wait   (tx_wait)
   );

endmodule

`default_nettype wire

// File: logic/link_tx_io.sv
/*
 tx io block
 access flop under tx_wait, behavioural ddr output of the 32-bit word
*/
`default_nettype none

module link_tx_io (
   input  logic                         clk,
   input  logic                         rst_n,
   // core side
   input  logic                         io_access,
   input  link_pkg::link_word_t         io_packet,
   output logic                         io_taken,
   // pins
   output logic                         tx_access,
   output logic [link_pkg::link_iow-1:0] tx_packet,
   input  logic                         tx_wait     // far end pushback
);
   import link_pkg::*;

   logic [link_iow-1:0] lo_q;     // low half, rising edge
   logic [link_iow-1:0] hi_q;     // high half, rising edge
   logic [link_iow-1:0] hi_neg;   // high half re-timed on falling edge

   assign io_taken = io_access && !tx_wait;

   //########################################
   //# access (sdr)
   //########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tx_access <= 1'b0;
      else if (!tx_wait)
         tx_access <= io_access;   // hold under wait
   end

   //########################################
   //# data (ddr model)
   //########################################

   // capture both halves together
   always_ff @(posedge clk) begin
      if (io_taken) begin
         lo_q <= io_packet[link_iow-1:0];
         hi_q <= io_packet[link_word_w-1:link_iow];
      end
   end

   always_ff @(negedge clk) begin
      hi_neg <= hi_q;
   end

   // low half while clk high, high half while clk low
   assign tx_packet = clk ? lo_q : hi_neg;

endmodule

`default_nettype wire

// File: logic/link_tx_ctrl.sv
/*
 tx control: wishbone register slave and word sequencer
 pushes txdata writes into the fifo, feeds one word at a time to the io block
*/
`default_nettype none

module link_tx_ctrl #(
   parameter int fifo_depth = 8
) (
   input  logic                 clk,
   input  logic                 rst_n,
   // host
   input  link_pkg::wb_req_t    wb_req,
   output link_pkg::wb_rsp_t    wb_rsp,
   // fifo
   output logic                 push,
   output link_pkg::link_word_t push_data,
   output logic                 pop,
   input  link_pkg::link_word_t pop_data,
   input  logic [15:0]          count,
   input  logic                 full,
   input  logic                 empty,
   // io block
   output logic                 io_access,
   output link_pkg::link_word_t io_packet,
   input  logic                 io_taken
);
   import link_pkg::*;

   logic             req;         // cyc and stb
   logic             busy;        // request sampled, ack pending
   logic             txdata_wr;   // write aimed at txdata
   logic             go;          // complete the access this edge
   logic             ack_q;
   link_word_t       rdat_q;      // read data register
   link_word_t       rd_mux;
   link_word_t       status;
   logic             enable;
   logic [31:0]      sent;

   //########################################
   //# wishbone slave
   //########################################

   assign req       = wb_req.cyc && wb_req.stb;
   assign txdata_wr = wb_req.we && (wb_req.adr == reg_txdata);
   assign go        = busy && req && !(txdata_wr && full);   // stall on full

   // first edge samples the request, second edge acks
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         ack_q <= go;
         if (go || !req)
            busy <= 1'b0;        // done, or master gave up
         else if (!ack_q)
            busy <= 1'b1;        // not the tail of the last access
      end
   end

   // push lands on the ack edge
   assign push      = busy && req && txdata_wr && !full;
   assign push_data = wb_req.dat;

   // ctrl register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         enable <= 1'b0;
      else if (go && wb_req.we && (wb_req.adr == reg_ctrl))
         enable <= wb_req.dat[0];
   end

   // words accepted by the io block, wraps
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         sent <= '0;
      else if (io_taken)
         sent <= sent + 1'b1;
   end

   assign status = {14'd0, full, empty, count};

   always_comb begin
      case (wb_req.adr)
         reg_ctrl:   rd_mux = {31'd0, enable};
         reg_status: rd_mux = status;
         reg_sent:   rd_mux = sent;
         default:    rd_mux = '0;   // txdata is write only
      endcase
   end

   always_ff @(posedge clk) begin
      if (go)
         rdat_q <= rd_mux;   // valid with ack
   end

   assign wb_rsp = '{ack: ack_q, dat: rdat_q};

   //########################################
   //# sequencer
   //########################################

   // refill when idle or when the current word leaves
   assign pop = enable && !empty && (!io_access || io_taken);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         io_access <= 1'b0;
      else if (pop)
         io_access <= 1'b1;   // back to back
      else if (io_taken)
         io_access <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (pop)
         io_packet <= pop_data;   // head word
   end

   // checks
   a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |=> !wb_rsp.ack)
      else $error("ack held longer than one cycle");

   a_io_hold: assert property (@(posedge clk) disable iff (!rst_n)
      io_access && !io_taken |=> io_access && $stable(io_packet))
      else $error("io word changed before it was taken");

   a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
      count <= 16'(fifo_depth))
      else $error("fifo count beyond depth");

endmodule

`default_nettype wire

// File: logic/link_tx_fifo.sv
/*
 tx word fifo
 circular buffer, show-ahead head, count from pointer difference
*/
`default_nettype none

module link_tx_fifo #(
   parameter int fifo_depth = 8   // power of two
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 push,
   input  link_pkg::link_word_t push_data,
   input  logic                 pop,
   output link_pkg::link_word_t pop_data,
   output logic [15:0]          count,
   output logic                 full,
   output logic                 empty
);
   import link_pkg::*;

   localparam int aw = $clog2(fifo_depth);   // address bits

   link_word_t   mem [fifo_depth];  // storage, no reset
   logic [aw:0]  wr_ptr;            // extra msb for wrap
   logic [aw:0]  rd_ptr;
   logic [aw:0]  fill;

   //########################################
   //# pointers
   //########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   //########################################
   //# storage
   //########################################

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr[aw-1:0]] <= push_data;
   end

   assign pop_data = mem[rd_ptr[aw-1:0]];   // head, valid when !empty

   // flags
   assign fill  = wr_ptr - rd_ptr;
   assign count = 16'(fill);
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[aw] != rd_ptr[aw]) &&
                  (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);   // same slot, other lap

   // controller must respect the flags
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      full |-> !push)
      else $error("fifo push while full");

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      empty |-> !pop)
      else $error("fifo pop while empty");

endmodule

`default_nettype wire

// File: logic/link_reset_sync.sv
/*
 reset synchronizer
 async assert, release two rising edges after io_nreset goes high
*/
`default_nettype none

module link_reset_sync (
   input  logic clk,
   input  logic io_nreset,   // raw pin reset, active low
   output logic rst_n        // synchronized reset
);

   logic [1:0] sync_q;   // two stage chain

   always_ff @(posedge clk or negedge io_nreset) begin
      if (!io_nreset)
         sync_q <= 2'b00;              // assert at once
      else
         sync_q <= {sync_q[0], 1'b1};  // shift the release in
   end

   assign rst_n = sync_q[1];

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
/*
 link tx package
 widths, register map and wishbone request/response structs
*/
`default_nettype none

package link_pkg;

   //########################################
   //# link widths
   //########################################

   localparam int link_iow    = 16;           // pin bus width
   localparam int link_word_w = 2*link_iow;   // one word per ddr beat pair

   // word as handed from fifo to io block
   typedef logic [link_word_w-1:0] link_word_t;

   //########################################
   //# register map (word addresses)
   //########################################

   localparam logic [1:0] reg_ctrl   = 2'd0;  // bit 0 enable
   localparam logic [1:0] reg_status = 2'd1;  // {full, empty, count}
   localparam logic [1:0] reg_sent   = 2'd2;  // words taken by io
   localparam logic [1:0] reg_txdata = 2'd3;  // write pushes a word

   //########################################
   //# wishbone classic
   //########################################

   // host side request, 37 bits
   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [1:0]             adr;   // word address
      logic [link_word_w-1:0] dat;   // write data
   } wb_req_t;

   // slave response, 33 bits
   typedef struct packed {
      logic                   ack;   // single cycle
      logic [link_word_w-1:0] dat;   // read data, valid with ack
   } wb_rsp_t;

endpackage

`default_nettype wire
